/* flist.f */
design/decode_pkg.sv
design/insn_decoder.sv
design/operand_extract.sv
design/decode_stage_reg.sv
design/issue_steer.sv
design/decode_top.sv
verification/tb_clkgen.sv
verification/decode_assert.sv
verification/decode_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module decode_tb -f flist.f -o decode_sim || exit 1
out=$(./obj_dir/decode_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF -- '** PASS **' && exit 0 || exit 1

/* verification/decode_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_tb;
    import decode_pkg::*;

    localparam int PC_W          = 32;
    localparam int RESET_TIMEOUT = 20;

    typedef struct packed {
        logic [31:0] insn;
        logic        vld;
        logic        flush;
        logic        hold;
        logic [1:0]  rnd;       // 1 rd and rj, 2 adds rk
        iq_sel_e     iq;
        logic [4:0]  op;        // Op of the selected unit
        logic [25:0] imm;       // Immediate of the selected unit
        logic [2:0]  en;        // dst src1 src2
        reg_idx_t    dst;
        reg_idx_t    src1;
        reg_idx_t    src2;
        logic        legal;
        logic        illegal;
    } row_t;

    logic            clk;
    logic            rst_n;
    logic            flush;
    logic            hold;
    logic            instruction_vld;
    logic [31:0]     instruction;
    logic [PC_W-1:0] pc_in;
    logic            dec_valid;
    logic            illegal;
    iq_sel_e         iq_sel;
    unit_ops_t       ops;
    logic [19:0]     imm_alu0;
    logic [16:0]     imm_agu;
    logic [25:0]     imm_bru;
    logic            dst_en;
    reg_idx_t        dst;
    logic            src1_en;
    reg_idx_t        src1;
    logic            src2_en;
    reg_idx_t        src2;
    logic [PC_W-1:0] pc_out;

    row_t        rows[$];
    logic [31:0] lfsr;
    int          n_checks;
    int          n_errors;

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    decode_top #(
        .PC_W (PC_W)
    ) dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .hold            (hold),
        .instruction_vld (instruction_vld),
        .instruction     (instruction),
        .pc_in           (pc_in),
        .dec_valid       (dec_valid),
        .illegal         (illegal),
        .iq_sel          (iq_sel),
        .ops             (ops),
        .imm_alu0        (imm_alu0),
        .imm_agu         (imm_agu),
        .imm_bru         (imm_bru),
        .dst_en          (dst_en),
        .dst             (dst),
        .src1_en         (src1_en),
        .src1            (src1),
        .src2_en         (src2_en),
        .src2            (src2),
        .pc_out          (pc_out)
    );

    task automatic add_row(input logic [31:0] insn, input logic [2:0] ctl, input int rnd,
                           input iq_sel_e iq, input int op, input logic [25:0] imm,
                           input logic [2:0] en, input int rd, input int rj, input int rk,
                           input logic [1:0] flags);
        row_t r;
        r.insn    = insn;
        r.vld     = ctl[2];
        r.flush   = ctl[1];
        r.hold    = ctl[0];
        r.rnd     = 2'(rnd);
        r.iq      = iq;
        r.op      = 5'(op);
        r.imm     = imm;
        r.en      = en;
        r.dst     = 5'(rd);
        r.src1    = 5'(rj);
        r.src2    = 5'(rk);
        r.legal   = flags[1];
        r.illegal = flags[0];
        rows.push_back(r);
    endtask

    task automatic build_table();
        // word          vld/fl/hd rnd queue   op imm          en    rd rj rk  flags
        add_row(32'h001018A4, 3'b100, 0, IQ_ALU0, 7, 26'h406, 3'b111, 4, 5, 6, 2'b10);
        add_row(32'h00112507, 3'b100, 0, IQ_ALU0, 8, 26'h449, 3'b111, 7, 8, 9, 2'b10);
        add_row(32'h029FFC00, 3'b100, 1, IQ_ALU0, 3, 26'h7FF, 3'b110, 0, 0, 0, 2'b10);
        add_row(32'h03A96800, 3'b100, 1, IQ_ALU0, 5, 26'hA5A, 3'b110, 0, 0, 0, 2'b10);
        add_row(32'h00408C41, 3'b100, 0, IQ_ALU0, 21, 26'h023, 3'b110, 1, 2, 0, 2'b10);
        add_row(32'h0048FD4B, 3'b100, 0, IQ_ALU0, 23, 26'h23F, 3'b110, 11, 10, 0, 2'b10);
        add_row(32'h15579BCC, 3'b100, 0, IQ_ALU0, 0, 26'hABCDE, 3'b100, 12, 0, 0, 2'b10);
        add_row(32'h001C0000, 3'b100, 2, IQ_ALU1, 4, 26'h0, 3'b111, 0, 0, 0, 2'b10);
        add_row(32'h001D0000, 3'b100, 2, IQ_ALU1, 6, 26'h0, 3'b111, 0, 0, 0, 2'b10);
        add_row(32'h00200000, 3'b100, 2, IQ_ALU1, 0, 26'h0, 3'b111, 0, 0, 0, 2'b10);
        add_row(32'h00218000, 3'b100, 2, IQ_ALU1, 3, 26'h0, 3'b111, 0, 0, 0, 2'b10);
        add_row(32'h28848C00, 3'b100, 1, IQ_AGU, 9, 26'h123, 3'b110, 0, 0, 0, 2'b10);
        add_row(32'h2A3FFC00, 3'b100, 1, IQ_AGU, 13, 26'hFFF, 3'b110, 0, 0, 0, 2'b10);
        add_row(32'h29A00000, 3'b100, 1, IQ_AGU, 12, 26'h800, 3'b011, 0, 0, 0, 2'b10);
        add_row(32'h29001000, 3'b100, 1, IQ_AGU, 10, 26'h004, 3'b011, 0, 0, 0, 2'b10);
        add_row(32'h5559E034, 3'b100, 0, IQ_BRU, 3, 26'h0345678, 3'b100, 1, 0, 0, 2'b10);
        add_row(32'h53FFF3FF, 3'b100, 0, IQ_BRU, 2, 26'h3FFFFFC, 3'b000, 0, 0, 0, 2'b10);
        add_row(32'h4C004000, 3'b100, 1, IQ_BRU, 1, 26'h0010, 3'b110, 0, 0, 0, 2'b10);
        add_row(32'h5BFFC000, 3'b100, 1, IQ_BRU, 4, 26'hFFF0, 3'b011, 0, 0, 0, 2'b10);
        add_row(32'h68040000, 3'b100, 1, IQ_BRU, 8, 26'h0100, 3'b011, 0, 0, 0, 2'b10);
        add_row(32'h1C2468A3, 3'b100, 0, IQ_BRU, 0, 26'h12345, 3'b000, 0, 0, 0, 2'b10);
        add_row(32'h04000401, 3'b100, 0, IQ_NONE, 0, 26'h0, 3'b000, 0, 0, 0, 2'b01);  // CSR
        add_row(32'hFFFFFFFF, 3'b100, 0, IQ_NONE, 0, 26'h0, 3'b000, 0, 0, 0, 2'b01);
        add_row(32'h001018A4, 3'b000, 0, IQ_NONE, 0, 26'h0, 3'b000, 0, 0, 0, 2'b00);
        add_row(32'h1C2468A3, 3'b100, 0, IQ_BRU, 0, 26'h12345, 3'b000, 0, 0, 0, 2'b10);
        add_row(32'h28848C00, 3'b101, 0, IQ_NONE, 0, 26'h0, 3'b000, 0, 0, 0, 2'b00);
        add_row(32'h001C0000, 3'b101, 0, IQ_NONE, 0, 26'h0, 3'b000, 0, 0, 0, 2'b00);
        add_row(32'h001018A4, 3'b111, 0, IQ_NONE, 0, 26'h0, 3'b000, 0, 0, 0, 2'b00);
        add_row(32'h001018A4, 3'b100, 0, IQ_ALU0, 7, 26'h406, 3'b111, 4, 5, 6, 2'b10);
        add_row(32'h00112507, 3'b110, 0, IQ_NONE, 0, 26'h0, 3'b000, 0, 0, 0, 2'b00);
        add_row(32'h00112507, 3'b000, 0, IQ_NONE, 0, 26'h0, 3'b000, 0, 0, 0, 2'b00);
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic reg_idx_t take_field();
        logic     fb;
        reg_idx_t v;
        v = '0;
        for (int b = 0; b < 5; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[3:0], fb};
        end
        return v;
    endfunction

    function automatic unit_ops_t expect_ops(input iq_sel_e iq, input logic [4:0] op);
        unit_ops_t o;
        o = '0;
        case (iq)
            IQ_ALU0: o.alu0 = alu0_op_e'(op);
            IQ_ALU1: o.alu1 = alu1_op_e'(op[2:0]);
            IQ_AGU:  o.agu  = agu_op_e'(op[3:0]);
            IQ_BRU:  o.bru  = bru_op_e'(op[3:0]);
            default: o = '0;
        endcase
        return o;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("[FAIL] %0t %s exp=%b got=%b", $time, name, want, got);
        end
    endtask

    task automatic check_iq(input string name, input iq_sel_e got, input iq_sel_e want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("[FAIL] %0t %s exp=%b got=%b", $time, name, want, got);
        end
    endtask

    task automatic check_ops(input string name, input unit_ops_t got, input unit_ops_t want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("[FAIL] %0t %s exp=%h got=%h", $time, name, want, got);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("[FAIL] %0t %s exp=%0d got=%0d", $time, name, want, got);
        end
    endtask

    task automatic check_imm(input string name, input logic [25:0] got,
                             input logic [25:0] want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("[FAIL] %0t %s exp=%h got=%h", $time, name, want, got);
        end
    endtask

    task automatic check_pc(input string name, input logic [31:0] got, input logic [31:0] want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("[FAIL] %0t %s exp=%h got=%h", $time, name, want, got);
        end
    endtask

    task automatic check_outputs(input row_t want, input logic [31:0] want_pc);
        check_bit("dec_valid", dec_valid, want.legal);
        check_bit("illegal", illegal, want.illegal);
        check_iq("iq_sel", iq_sel, want.iq);
        check_ops("ops", ops, expect_ops(want.iq, want.op));
        check_imm("imm_alu0", {6'd0, imm_alu0}, (want.iq == IQ_ALU0) ? want.imm : 26'd0);
        check_imm("imm_agu", {9'd0, imm_agu}, (want.iq == IQ_AGU) ? want.imm : 26'd0);
        check_imm("imm_bru", imm_bru, (want.iq == IQ_BRU) ? want.imm : 26'd0);
        check_bit("dst_en", dst_en, want.en[2]);
        check_bit("src1_en", src1_en, want.en[1]);
        check_bit("src2_en", src2_en, want.en[0]);
        if (want.en[2]) check_reg("dst", dst, want.dst);     // Fields only matter when read
        if (want.en[1]) check_reg("src1", src1, want.src1);
        if (want.en[0]) check_reg("src2", src2, want.src2);
        check_pc("pc_out", pc_out, want_pc);
    endtask

    initial begin
        row_t        r;
        row_t        want;
        logic [31:0] want_pc;
        logic [31:0] pc;
        reg_idx_t    rd;
        reg_idx_t    rj;
        reg_idx_t    rk;
        int          wait_cnt;

        flush           = 1'b0;
        hold            = 1'b0;
        instruction_vld = 1'b0;
        instruction     = '0;
        pc_in           = '0;
        lfsr            = 32'hbd02fa76;
        n_checks        = 0;
        n_errors        = 0;
        build_table();

        wait_cnt = 0;
        while (rst_n !== 1'b1 && wait_cnt < RESET_TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end

        if (rst_n !== 1'b1) begin
            $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("** FAIL **");
        end else begin
            want    = '0;                                // Reset state
            want_pc = '0;
            for (int i = 0; i <= rows.size(); i++) begin
                @(posedge clk);
                #1;
                check_outputs(want, want_pc);
                if (i < rows.size()) begin
                    r  = rows[i];
                    pc = 32'h1c00_0000 + 32'(i) * 32'd4;
                    rd = '0;
                    rj = '0;
                    rk = '0;
                    if (r.rnd != 2'd0) begin
                        rd = take_field();
                        rj = take_field();
                        if (r.rnd == 2'd2) rk = take_field();
                        r.dst  = rd;
                        r.src1 = rj;
                        r.src2 = (r.iq == IQ_ALU1) ? rk : rd;   // Stores and branches read rd
                    end
                    instruction     = r.insn | {17'd0, rk, rj, rd};
                    instruction_vld = r.vld;
                    flush           = r.flush;
                    hold            = r.hold;
                    pc_in           = pc;
                    if (r.flush || (!r.hold && !r.vld)) begin
                        want = '0;
                    end else if (!r.hold) begin
                        want = r;
                    end
                    if (r.vld && !r.flush && !r.hold) want_pc = pc;
                end
            end
            $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
            if (n_errors == 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/decode_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_assert #(
    parameter int PC_W = 32
) (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  flush,
    input logic                  hold,
    input logic                  instruction_vld,
    input logic [PC_W-1:0]       pc_in,
    input logic                  dec_valid,
    input logic                  illegal,
    input decode_pkg::iq_sel_e   iq_sel,
    input decode_pkg::unit_ops_t ops,
    input logic                  dst_en,
    input logic [PC_W-1:0]       pc_out
);
    import decode_pkg::*;

    a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> (!dec_valid && !illegal))
        else $error("outputs not cleared after flush");

    a_idle_clears: assert property (@(posedge clk) disable iff (!rst_n)
        (!flush && !hold && !instruction_vld) |=> (!dec_valid && !illegal))
        else $error("outputs not cleared after a strobe-low cycle");

    a_hold_outputs: assert property (@(posedge clk) disable iff (!rst_n)
        (hold && !flush) |=> $stable({dec_valid, illegal, iq_sel, ops, dst_en}))
        else $error("outputs moved during hold");

    a_hold_pc: assert property (@(posedge clk) disable iff (!rst_n)
        (hold && !flush) |=> $stable(pc_out))
        else $error("pc_out moved during hold");

    a_take_pc: assert property (@(posedge clk) disable iff (!rst_n)
        (instruction_vld && !flush && !hold) |=> (pc_out == $past(pc_in)))
        else $error("pc_out is not the PC of the accepted word");

endmodule

bind decode_top decode_assert #(
    .PC_W (PC_W)
) u_decode_assert (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush           (flush),
    .hold            (hold),
    .instruction_vld (instruction_vld),
    .pc_in           (pc_in),
    .dec_valid       (dec_valid),
    .illegal         (illegal),
    .iq_sel          (iq_sel),
    .ops             (ops),
    .dst_en          (dst_en),
    .pc_out          (pc_out)
);

`default_nettype wire

/* verification/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                       // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;                             // Released just after the third edge
    end

endmodule

`default_nettype wire

/* design/decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_top #(
    parameter int PC_W = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  hold,
    input  logic                  instruction_vld,
    input  logic [31:0]           instruction,
    input  logic [PC_W-1:0]       pc_in,
    output logic                  dec_valid,
    output logic                  illegal,
    output decode_pkg::iq_sel_e   iq_sel,
    output decode_pkg::unit_ops_t ops,
    output logic [19:0]           imm_alu0,
    output logic [16:0]           imm_agu,
    output logic [25:0]           imm_bru,
    output logic                  dst_en,
    output decode_pkg::reg_idx_t  dst,
    output logic                  src1_en,
    output decode_pkg::reg_idx_t  src1,
    output logic                  src2_en,
    output decode_pkg::reg_idx_t  src2,
    output logic [PC_W-1:0]       pc_out
);
    import decode_pkg::*;

    iq_sel_e        iq_sel_d;
    unit_ops_t      ops_d;
    logic           legal_d;
    logic           dst_en_d;
    logic           src1_en_d;
    logic           src2_en_d;
    reg_idx_t       dst_d;
    reg_idx_t       src1_d;
    reg_idx_t       src2_d;
    imm_word_u      imm_d;
    decode_bundle_t bundle_d;
    decode_bundle_t bundle_q;

    insn_decoder u_insn_decoder (
        .instruction (instruction),
        .iq_sel      (iq_sel_d),
        .ops         (ops_d),
        .legal       (legal_d)
    );

    operand_extract u_operand_extract (
        .instruction (instruction),
        .iq_sel      (iq_sel_d),
        .dst_en      (dst_en_d),
        .dst         (dst_d),
        .src1_en     (src1_en_d),
        .src1        (src1_d),
        .src2_en     (src2_en_d),
        .src2        (src2_d),
        .imm         (imm_d)
    );

    assign bundle_d = '{
        legal:   legal_d,
        taken:   instruction_vld,
        iq_sel:  iq_sel_d,
        alu0_op: ops_d.alu0,
        alu1_op: ops_d.alu1,
        agu_op:  ops_d.agu,
        bru_op:  ops_d.bru,
        imm:     imm_d,
        dst_en:  dst_en_d,
        dst:     dst_d,
        src1_en: src1_en_d,
        src1:    src1_d,
        src2_en: src2_en_d,
        src2:    src2_d
    };

    decode_stage_reg #(
        .PC_W (PC_W)
    ) u_decode_stage_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .hold      (hold),
        .insn_vld  (instruction_vld),
        .pc_in     (pc_in),
        .bundle_in (bundle_d),
        .bundle_q  (bundle_q),
        .pc_out    (pc_out)
    );

    issue_steer u_issue_steer (
        .bundle_q  (bundle_q),
        .dec_valid (dec_valid),
        .illegal   (illegal),
        .iq_sel    (iq_sel),
        .ops       (ops),
        .imm_alu0  (imm_alu0),
        .imm_agu   (imm_agu),
        .imm_bru   (imm_bru),
        .dst_en    (dst_en),
        .dst       (dst),
        .src1_en   (src1_en),
        .src1      (src1),
        .src2_en   (src2_en),
        .src2      (src2)
    );

endmodule

`default_nettype wire

/* design/issue_steer.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_steer (
    input  decode_pkg::decode_bundle_t bundle_q,
    output logic                       dec_valid,
    output logic                       illegal,
    output decode_pkg::iq_sel_e        iq_sel,
    output decode_pkg::unit_ops_t      ops,
    output logic [19:0]                imm_alu0,
    output logic [16:0]                imm_agu,
    output logic [25:0]                imm_bru,
    output logic                       dst_en,
    output decode_pkg::reg_idx_t       dst,
    output logic                       src1_en,
    output decode_pkg::reg_idx_t       src1,
    output logic                       src2_en,
    output decode_pkg::reg_idx_t       src2
);
    import decode_pkg::*;

    assign dec_valid = bundle_q.legal;
    assign illegal   = bundle_q.taken && !bundle_q.legal;  // Strobed but undecodable
    assign iq_sel    = bundle_q.iq_sel;

    always_comb begin
        ops      = '0;
        imm_alu0 = '0;
        imm_agu  = '0;
        imm_bru  = '0;
        case (bundle_q.iq_sel)
            IQ_ALU0: begin
                ops.alu0 = bundle_q.alu0_op;
                imm_alu0 = bundle_q.imm.alu.val;
            end
            IQ_ALU1: ops.alu1 = bundle_q.alu1_op;
            IQ_AGU: begin
                ops.agu = bundle_q.agu_op;
                imm_agu = bundle_q.imm.agu.val;
            end
            IQ_BRU: begin
                ops.bru = bundle_q.bru_op;
                imm_bru = bundle_q.imm.bru;
            end
            default: ops = '0;
        endcase
    end

    assign dst_en  = bundle_q.legal && bundle_q.dst_en;
    assign src1_en = bundle_q.legal && bundle_q.src1_en;
    assign src2_en = bundle_q.legal && bundle_q.src2_en;
    assign dst     = bundle_q.dst;
    assign src1    = bundle_q.src1;
    assign src2    = bundle_q.src2;

endmodule

`default_nettype wire

/* design/decode_stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_reg #(
    parameter int PC_W = 32
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       hold,
    input  logic                       insn_vld,
    input  logic [PC_W-1:0]            pc_in,
    input  decode_pkg::decode_bundle_t bundle_in,
    output decode_pkg::decode_bundle_t bundle_q,
    output logic [PC_W-1:0]            pc_out
);
    import decode_pkg::*;

    logic load;

    assign load = !flush && !hold;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bundle_q <= '0;
        end else if (flush) begin                        // Wins over hold
            bundle_q <= '0;
        end else if (load) begin
            bundle_q <= insn_vld ? bundle_in : decode_bundle_t'('0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_out <= '0;
        end else if (load && insn_vld) begin
            pc_out <= pc_in;
        end
    end

endmodule

`default_nettype wire

/* design/operand_extract.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_extract (
    input  logic [31:0]           instruction,
    input  decode_pkg::iq_sel_e   iq_sel,
    output logic                  dst_en,
    output decode_pkg::reg_idx_t  dst,
    output logic                  src1_en,
    output decode_pkg::reg_idx_t  src1,
    output logic                  src2_en,
    output decode_pkg::reg_idx_t  src2,
    output decode_pkg::imm_word_u imm
);
    import decode_pkg::*;

    logic is_lu12i;
    logic is_pcaddu;
    logic is_bl;
    logic is_b_bl;
    logic is_jirl;
    logic is_3reg;
    logic is_cmp_br;

    assign is_lu12i  = (instruction[31:25] == 7'b0001010);
    assign is_pcaddu = (instruction[31:25] == 7'b0001110);
    assign is_bl     = (instruction[31:26] == 6'b010101);
    assign is_b_bl   = (instruction[31:27] == 5'b01010);
    assign is_jirl   = (instruction[31:26] == 6'b010011);
    assign is_3reg   = (instruction[31:20] == 12'h001);        // rd, rj, rk ALU forms
    assign is_cmp_br = (instruction[31:30] == 2'b01) && !is_jirl && !is_b_bl;

    always_comb begin
        dst_en  = 1'b0;
        src1_en = 1'b0;
        src2_en = 1'b0;
        case (iq_sel)
            IQ_ALU0: begin
                dst_en  = 1'b1;
                src1_en = !is_lu12i;
                src2_en = is_3reg;
            end
            IQ_ALU1: begin
                dst_en  = 1'b1;
                src1_en = 1'b1;
                src2_en = 1'b1;
            end
            IQ_AGU: begin
                dst_en  = !instruction[24];                     // Loads only
                src1_en = 1'b1;
                src2_en = instruction[24];                      // Store data in rd
            end
            IQ_BRU: begin
                dst_en  = is_jirl || is_bl;
                src1_en = !(is_pcaddu || is_b_bl);
                src2_en = is_cmp_br;
            end
            default: dst_en = 1'b0;
        endcase
    end

    assign dst  = is_bl ? 5'd1 : instruction[4:0];              // BL links to r1
    assign src1 = instruction[9:5];
    assign src2 = (iq_sel inside {IQ_AGU, IQ_BRU}) ? instruction[4:0] : instruction[14:10];

    always_comb begin
        imm = '0;
        case (iq_sel)
            IQ_ALU0: imm.alu.val = is_lu12i ? instruction[24:5] : {8'd0, instruction[21:10]};
            IQ_AGU:  imm.agu.val = {5'd0, instruction[21:10]};
            IQ_BRU: begin
                if (is_pcaddu) begin
                    imm.bru = {6'd0, instruction[24:5]};
                end else if (is_b_bl) begin
                    imm.bru = {instruction[9:0], instruction[25:10]};  // offs[25:16] in low bits
                end else begin
                    imm.bru = {10'd0, instruction[25:10]};
                end
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/insn_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
    input  logic [31:0]           instruction,
    output decode_pkg::iq_sel_e   iq_sel,
    output decode_pkg::unit_ops_t ops,
    output logic                  legal
);
    import decode_pkg::*;

    alu0_op_e alu0_op;
    alu1_op_e alu1_op;
    agu_op_e  agu_op;
    bru_op_e  bru_op;

    always_comb begin
        iq_sel = IQ_NONE;
        casez (instruction[31:15])
            17'b0001010_??????????,                    // LU12I.W
            17'b0000001_00?_???????,                   // SLTI SLTUI
            17'b0000001_010_???????,                   // ADDI.W
            17'b0000001_101_???????,                   // ANDI
            17'b0000001_11?_???????,                   // ORI XORI
            17'b000000000001_00000,                    // ADD.W
            17'b000000000001_00010,                    // SUB.W
            17'b000000000001_0010?,                    // SLT SLTU
            17'b000000000001_010??,                    // NOR AND OR XOR
            17'b000000000001_0111?,                    // SLL.W SRL.W
            17'b000000000001_10000,                    // SRA.W
            17'b000000000100_00001,                    // SLLI.W
            17'b000000000100_01001,                    // SRLI.W
            17'b000000000100_10001:                    // SRAI.W
                iq_sel = IQ_ALU0;
            17'b000000000001_1100?,                    // MUL.W MULH.W
            17'b000000000001_11010,                    // MULH.WU
            17'b000000000010_000??:                    // DIV MOD DIVU MODU
                iq_sel = IQ_ALU1;
            17'b001010_000?_???????,                   // LD.B LD.H
            17'b001010_0010_???????,                   // LD.W
            17'b001010_010?_???????,                   // ST.B ST.H
            17'b001010_0110_???????,                   // ST.W
            17'b001010_100?_???????:                   // LD.BU LD.HU
                iq_sel = IQ_AGU;
            17'b0001110_??????????,                    // PCADDU12I
            17'b010011_???????????,                    // JIRL
            17'b01010?_???????????,                    // B BL
            17'b01011?_???????????,                    // BEQ BNE
            17'b01100?_???????????,                    // BLT BGE
            17'b01101?_???????????:                    // BLTU BGEU
                iq_sel = IQ_BRU;
            default:
                iq_sel = IQ_NONE;
        endcase
    end

    assign legal = (iq_sel != IQ_NONE);

    always_comb begin
        alu0_op = ALU0_LU12I;
        if (instruction[28]) begin
            alu0_op = ALU0_LU12I;
        end else if (instruction[25]) begin               // Immediate forms
            case (instruction[24:22])
                3'b000:  alu0_op = ALU0_SLTI;
                3'b001:  alu0_op = ALU0_SLTUI;
                3'b010:  alu0_op = ALU0_ADDI;
                3'b101:  alu0_op = ALU0_ANDI;
                3'b110:  alu0_op = ALU0_ORI;
                3'b111:  alu0_op = ALU0_XORI;
                default: alu0_op = ALU0_LU12I;
            endcase
        end else if (instruction[22]) begin               // Shift by ui5
            case (instruction[19:18])
                2'b00:   alu0_op = ALU0_SLLI;
                2'b01:   alu0_op = ALU0_SRLI;
                default: alu0_op = ALU0_SRAI;
            endcase
        end else begin
            case (instruction[19:15])
                5'b00000: alu0_op = ALU0_ADD;
                5'b00010: alu0_op = ALU0_SUB;
                5'b00100: alu0_op = ALU0_SLT;
                5'b00101: alu0_op = ALU0_SLTU;
                5'b01000: alu0_op = ALU0_NOR;
                5'b01001: alu0_op = ALU0_AND;
                5'b01010: alu0_op = ALU0_OR;
                5'b01011: alu0_op = ALU0_XOR;
                5'b01110: alu0_op = ALU0_SLL;
                5'b01111: alu0_op = ALU0_SRL;
                5'b10000: alu0_op = ALU0_SRA;
                default:  alu0_op = ALU0_LU12I;
            endcase
        end
    end

    always_comb begin
        if (instruction[21]) begin
            case (instruction[16:15])
                2'b00:   alu1_op = ALU1_DIV;
                2'b01:   alu1_op = ALU1_MOD;
                2'b10:   alu1_op = ALU1_DIVU;
                default: alu1_op = ALU1_MODU;
            endcase
        end else begin
            case (instruction[16:15])
                2'b00:   alu1_op = ALU1_MUL;
                2'b01:   alu1_op = ALU1_MULH;
                default: alu1_op = ALU1_MULHU;
            endcase
        end
    end

    always_comb begin
        case (instruction[25:22])
            4'b0000: agu_op = AGU_LD_B;
            4'b0001: agu_op = AGU_LD_H;
            4'b0010: agu_op = AGU_LD_W;
            4'b0100: agu_op = AGU_ST_B;
            4'b0101: agu_op = AGU_ST_H;
            4'b0110: agu_op = AGU_ST_W;
            4'b1000: agu_op = AGU_LD_BU;
            4'b1001: agu_op = AGU_LD_HU;
            default: agu_op = AGU_NONE;
        endcase
    end

    always_comb begin
        if (!instruction[30]) begin
            bru_op = BRU_PCADDU12I;
        end else begin
            case (instruction[29:26])
                4'b0011: bru_op = BRU_JIRL;
                4'b0100: bru_op = BRU_B;
                4'b0101: bru_op = BRU_BL;
                4'b0110: bru_op = BRU_BEQ;
                4'b0111: bru_op = BRU_BNE;
                4'b1000: bru_op = BRU_BLT;
                4'b1001: bru_op = BRU_BGE;
                4'b1010: bru_op = BRU_BLTU;
                4'b1011: bru_op = BRU_BGEU;
                default: bru_op = BRU_PCADDU12I;
            endcase
        end
    end

    assign ops = '{alu0: alu0_op, alu1: alu1_op, agu: agu_op, bru: bru_op};

endmodule

`default_nettype wire

/* design/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    typedef enum logic [3:0] {
        IQ_NONE = 4'b0000,
        IQ_BRU  = 4'b0001,
        IQ_AGU  = 4'b0010,
        IQ_ALU1 = 4'b0100,
        IQ_ALU0 = 4'b1000
    } iq_sel_e;

    typedef enum logic [4:0] {
        ALU0_LU12I = 5'd0,
        ALU0_SLTI  = 5'd1,
        ALU0_SLTUI = 5'd2,
        ALU0_ADDI  = 5'd3,
        ALU0_ANDI  = 5'd4,
        ALU0_ORI   = 5'd5,
        ALU0_XORI  = 5'd6,
        ALU0_ADD   = 5'd7,
        ALU0_SUB   = 5'd8,
        ALU0_SLT   = 5'd9,
        ALU0_SLTU  = 5'd10,
        ALU0_NOR   = 5'd11,
        ALU0_AND   = 5'd12,
        ALU0_OR    = 5'd13,
        ALU0_XOR   = 5'd14,
        ALU0_SLL   = 5'd15,
        ALU0_SRL   = 5'd16,
        ALU0_SRA   = 5'd17,
        ALU0_SLLI  = 5'd21,
        ALU0_SRLI  = 5'd22,
        ALU0_SRAI  = 5'd23
    } alu0_op_e;

    typedef enum logic [2:0] {
        ALU1_DIV   = 3'd0,
        ALU1_MOD   = 3'd1,
        ALU1_DIVU  = 3'd2,
        ALU1_MODU  = 3'd3,
        ALU1_MUL   = 3'd4,
        ALU1_MULH  = 3'd5,
        ALU1_MULHU = 3'd6
    } alu1_op_e;

    typedef enum logic [3:0] {
        AGU_NONE  = 4'd0,
        AGU_LD_B  = 4'd7,
        AGU_LD_H  = 4'd8,
        AGU_LD_W  = 4'd9,
        AGU_ST_B  = 4'd10,
        AGU_ST_H  = 4'd11,
        AGU_ST_W  = 4'd12,
        AGU_LD_BU = 4'd13,
        AGU_LD_HU = 4'd14
    } agu_op_e;

    typedef enum logic [3:0] {
        BRU_PCADDU12I = 4'd0,
        BRU_JIRL      = 4'd1,
        BRU_B         = 4'd2,
        BRU_BL        = 4'd3,
        BRU_BEQ       = 4'd4,
        BRU_BNE       = 4'd5,
        BRU_BLT       = 4'd6,
        BRU_BGE       = 4'd7,
        BRU_BLTU      = 4'd8,
        BRU_BGEU      = 4'd9
    } bru_op_e;

    typedef logic [4:0] reg_idx_t;

    typedef struct packed {
        logic [5:0]  pad;
        logic [19:0] val;     // si20 or 12-bit field
    } imm_alu_t;

    typedef struct packed {
        logic [8:0]  pad;
        logic [16:0] val;
    } imm_agu_t;

    typedef union packed {
        imm_alu_t    alu;
        imm_agu_t    agu;
        logic [25:0] bru;     // Full offs26 width
    } imm_word_u;

    typedef struct packed {
        logic      legal;
        logic      taken;     // Slot holds a strobed word
        iq_sel_e   iq_sel;
        alu0_op_e  alu0_op;
        alu1_op_e  alu1_op;
        agu_op_e   agu_op;
        bru_op_e   bru_op;
        imm_word_u imm;
        logic      dst_en;
        reg_idx_t  dst;
        logic      src1_en;
        reg_idx_t  src1;
        logic      src2_en;
        reg_idx_t  src2;
    } decode_bundle_t;

    typedef struct packed {
        alu0_op_e alu0;
        alu1_op_e alu1;
        agu_op_e  agu;
        bru_op_e  bru;
    } unit_ops_t;

endpackage

`default_nettype wire
